// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: aes_axil_read.sv
`timescale 1ns/1ps
module aes_axil_read #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  aes_block_if.monitor      blk
);

  localparam logic [ADDR_W-1:0] KEY_A  = ADDR_W'(aes_pkg::REG_KEY0);
  localparam logic [ADDR_W-1:0] PT_A   = ADDR_W'(aes_pkg::REG_PT0);
  localparam logic [ADDR_W-1:0] CTRL_A = ADDR_W'(aes_pkg::REG_CTRL);
  localparam logic [ADDR_W-1:0] STAT_A = ADDR_W'(aes_pkg::REG_STATUS);
  localparam logic [ADDR_W-1:0] CT_A   = ADDR_W'(aes_pkg::REG_CT0);

  logic        accept;
  logic [1:0]  word;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;

  assign accept = arvalid && arready;
  assign word   = araddr[3:2];

  always_comb
  begin
    rd_data = '0;
    rd_resp = aes_pkg::RESP_OKAY;
    if (araddr[ADDR_W-1:4] == PT_A[ADDR_W-1:4])
      rd_data = blk.plaintext.cols[word];
    else if (araddr[ADDR_W-1:4] == CT_A[ADDR_W-1:4])
      rd_data = blk.ciphertext.cols[word];
    else if (araddr[ADDR_W-1:2] == STAT_A[ADDR_W-1:2])
      rd_data = {30'b0, blk.done, blk.busy};
    else if (araddr[ADDR_W-1:4] != KEY_A[ADDR_W-1:4]
             && araddr[ADDR_W-1:2] != CTRL_A[ADDR_W-1:2])
      rd_resp = aes_pkg::RESP_SLVERR;  // outside the map, data stays zero
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else if (accept)
    begin
      arready <= 1'b0;  // one read outstanding
      rvalid  <= 1'b1;
    end
    else if (rvalid && rready)
    begin
      rvalid  <= 1'b0;
      arready <= 1'b1;
    end
    else if (!rvalid)
      arready <= 1'b1;  // first cycle out of reset
  end

  // held until the next acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  a_r_stable: assert property (@(posedge clk) disable iff (!reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: aes_axil_write.sv
`timescale 1ns/1ps
module aes_axil_write #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  aes_block_if.host         blk
);

  localparam logic [ADDR_W-1:0] KEY_A  = ADDR_W'(aes_pkg::REG_KEY0);
  localparam logic [ADDR_W-1:0] PT_A   = ADDR_W'(aes_pkg::REG_PT0);
  localparam logic [ADDR_W-1:0] CTRL_A = ADDR_W'(aes_pkg::REG_CTRL);
  localparam logic [ADDR_W-1:0] STAT_A = ADDR_W'(aes_pkg::REG_STATUS);
  localparam logic [ADDR_W-1:0] CT_A   = ADDR_W'(aes_pkg::REG_CT0);

  logic                accept;
  logic                is_key, is_pt, is_ctrl, is_stat, is_ct;
  logic                mapped;
  logic [1:0]          word;
  aes_pkg::aes_block_u key_q;
  aes_pkg::aes_block_u pt_q;

  assign accept  = awvalid && wvalid && !bvalid;  // aw and w taken together
  assign awready = accept;
  assign wready  = accept;

  assign word    = awaddr[3:2];                                // word inside a block
  assign is_key  = awaddr[ADDR_W-1:4] == KEY_A[ADDR_W-1:4];   // 4-word block
  assign is_pt   = awaddr[ADDR_W-1:4] == PT_A[ADDR_W-1:4];
  assign is_ct   = awaddr[ADDR_W-1:4] == CT_A[ADDR_W-1:4];    // read only, ok
  assign is_ctrl = awaddr[ADDR_W-1:2] == CTRL_A[ADDR_W-1:2];
  assign is_stat = awaddr[ADDR_W-1:2] == STAT_A[ADDR_W-1:2];  // read only, ok
  assign mapped  = is_key || is_pt || is_ctrl || is_stat || is_ct;

  // start dropped while a block runs, write still answers okay
  assign blk.start     = accept && is_ctrl && wdata[0] && !blk.busy;
  assign blk.key       = key_q;
  assign blk.plaintext = pt_q;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      key_q <= '0;
      pt_q  <= '0;
    end
    else if (accept)
    begin
      for (int k = 0; k < 4; k++)
      begin
        // lane 3 holds the lowest byte of the word
        if (wstrb[k] && is_key)
          key_q.bytes[4 * int'(word) + 3 - k] <= wdata[8*k +: 8];
        if (wstrb[k] && is_pt)
          pt_q.bytes[4 * int'(word) + 3 - k] <= wdata[8*k +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      bvalid <= 1'b0;
      bresp  <= aes_pkg::RESP_OKAY;
    end
    else if (accept)
    begin
      bvalid <= 1'b1;  // response one cycle after acceptance
      bresp  <= mapped ? aes_pkg::RESP_OKAY : aes_pkg::RESP_SLVERR;
    end
    else if (bready)
      bvalid <= 1'b0;
  end

  a_bresp_hold: assert property (@(posedge clk) disable iff (!reset)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // a start is seen by the core as busy on the next cycle
  a_start_idle: assert property (@(posedge clk) disable iff (!reset)
    blk.start |-> !blk.busy ##1 blk.busy);

endmodule

// File: aes_block_if.sv
`timescale 1ns/1ps
interface aes_block_if;

  logic                start;       // one-cycle pulse, only while idle
  aes_pkg::aes_block_u key;
  aes_pkg::aes_block_u plaintext;
  logic                busy;        // rounds in progress
  logic                done;        // ciphertext valid
  aes_pkg::aes_block_u ciphertext;

  // register side
  modport host (output start, key, plaintext, input busy);

  // encryptor
  modport engine (input start, key, plaintext, output busy, done, ciphertext);

  // readback side
  modport monitor (input plaintext, busy, done, ciphertext);

endinterface

// File: aes_core.sv
`timescale 1ns/1ps
module aes_core (
  input  logic        clk,
  input  logic        reset,
  aes_block_if.engine blk
);

  aes_pkg::aes_block_u state_q;    // running state
  aes_pkg::aes_block_u round_key;  // key for the round done this cycle
  aes_pkg::aes_block_u round_out;
  aes_pkg::aes_block_u ct_q;
  logic [3:0]          round_q;    // 1..NUM_ROUNDS while busy
  logic                busy_q;
  logic                done_q;
  logic                last;

  assign last = round_q == 4'(aes_pkg::NUM_ROUNDS);

  aes_key_sched i_key_sched (
    .clk       (clk),
    .reset     (reset),
    .load      (blk.start),
    .advance   (busy_q),
    .key_in    (blk.key),
    .round     (round_q),
    .round_key (round_key)
  );

  aes_round i_round (
    .state_in    (state_q),
    .round_key   (round_key),
    .final_round (last),
    .state_out   (round_out)
  );

  always_ff @(posedge clk)
  begin
    if (blk.start)
      state_q <= blk.plaintext ^ blk.key;  // initial addroundkey
    else if (busy_q)
      state_q <= round_out;
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      round_q <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      ct_q    <= '0;
    end
    else if (blk.start)
    begin
      round_q <= 4'd1;
      busy_q  <= 1'b1;
      done_q  <= 1'b0;  // old result gone
    end
    else if (busy_q)
    begin
      if (last)
      begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
        ct_q   <= round_out;  // output of round 10
      end
      else
        round_q <= round_q + 4'd1;
    end
  end

  assign blk.busy       = busy_q;
  assign blk.done       = done_q;
  assign blk.ciphertext = ct_q;

  a_round_range: assert property (@(posedge clk) disable iff (!reset)
    round_q <= 4'(aes_pkg::NUM_ROUNDS));

endmodule

// File: aes_key_sched.sv
`timescale 1ns/1ps
module aes_key_sched (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,       // take key_in
  input  logic                advance,    // step to next round key
  input  aes_pkg::aes_block_u key_in,
  input  logic [3:0]          round,      // round whose key is made now
  output aes_pkg::aes_block_u round_key
);

  aes_pkg::aes_block_u key_q;  // key of the previous round
  logic [31:0]         w3;
  logic [31:0]         temp;

  assign w3 = key_q.cols[3];

  // rotword, subword, then rcon into the top byte
  always_comb
  begin
    temp = {aes_pkg::sub_byte(w3[23:16]),
            aes_pkg::sub_byte(w3[15:8]),
            aes_pkg::sub_byte(w3[7:0]),
            aes_pkg::sub_byte(w3[31:24])};
    temp[31:24] = temp[31:24] ^ aes_pkg::rcon(round);
  end

  // xor chain across the four columns
  always_comb
  begin
    round_key.cols[0] = key_q.cols[0] ^ temp;
    round_key.cols[1] = key_q.cols[1] ^ round_key.cols[0];
    round_key.cols[2] = key_q.cols[2] ^ round_key.cols[1];
    round_key.cols[3] = key_q.cols[3] ^ round_key.cols[2];
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      key_q <= '0;
    else if (load)
      key_q <= key_in;     // round 0 key is the cipher key
    else if (advance)
      key_q <= round_key;  // same key the round used this cycle
  end

endmodule

// File: aes_pkg.sv
package aes_pkg;

  localparam int NUM_ROUNDS = 10;  // aes-128

  // one state or key, two views of the same 128 bits
  typedef union packed {
    logic [0:15][7:0] bytes;  // byte 0 in msb, fips-197 order
    logic [0:3][31:0] cols;   // column 0 in msb
  } aes_block_u;

  // byte offsets of the 32-bit registers
  localparam logic [7:0] REG_KEY0   = 8'h00;  // key words 0..3
  localparam logic [7:0] REG_PT0    = 8'h10;  // plaintext words 0..3
  localparam logic [7:0] REG_CTRL   = 8'h20;  // bit 0 starts a block
  localparam logic [7:0] REG_STATUS = 8'h24;  // bit 0 busy, bit 1 done
  localparam logic [7:0] REG_CT0    = 8'h30;  // ciphertext words 0..3

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // forward s-box, entry 0 leftmost
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    return SBOX[b];  // table lookup
  endfunction

  // multiply by 2 in gf(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // reduce when top bit fell out
  endfunction

  function automatic logic [7:0] rcon(input logic [3:0] round);
    logic [7:0] rc;
    case (round)
      4'd1:    rc = 8'h01;
      4'd2:    rc = 8'h02;
      4'd3:    rc = 8'h04;
      4'd4:    rc = 8'h08;
      4'd5:    rc = 8'h10;
      4'd6:    rc = 8'h20;
      4'd7:    rc = 8'h40;
      4'd8:    rc = 8'h80;
      4'd9:    rc = 8'h1b;  // wraps through the polynomial
      4'd10:   rc = 8'h36;
      default: rc = 8'h00;  // no round 0 key step
    endcase
    return rc;
  endfunction

endpackage

// File: aes_round.sv
`timescale 1ns/1ps
module aes_round (
  input  aes_pkg::aes_block_u state_in,
  input  aes_pkg::aes_block_u round_key,
  input  logic                final_round,  // no column mix in round 10
  output aes_pkg::aes_block_u state_out
);

  aes_pkg::aes_block_u shifted;  // after subbytes and shiftrows
  aes_pkg::aes_block_u mixed;

  // byte 4c+r is row r of column c
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        // row r rotates left by r columns
        shifted.bytes[4*c + r] = aes_pkg::sub_byte(state_in.bytes[4*((c + r) % 4) + r]);
      end
    end
  end

  // mixcolumns with the 2-3-1-1 circulant
  always_comb
  begin
    logic [7:0] s0, s1, s2, s3;
    mixed = shifted;
    for (int c = 0; c < 4; c++)
    begin
      s0 = shifted.bytes[4*c];
      s1 = shifted.bytes[4*c + 1];
      s2 = shifted.bytes[4*c + 2];
      s3 = shifted.bytes[4*c + 3];
      // 3x is 2x xor x
      mixed.bytes[4*c]     = aes_pkg::xtime(s0) ^ aes_pkg::xtime(s1) ^ s1 ^ s2 ^ s3;
      mixed.bytes[4*c + 1] = s0 ^ aes_pkg::xtime(s1) ^ aes_pkg::xtime(s2) ^ s2 ^ s3;
      mixed.bytes[4*c + 2] = s0 ^ s1 ^ aes_pkg::xtime(s2) ^ aes_pkg::xtime(s3) ^ s3;
      mixed.bytes[4*c + 3] = aes_pkg::xtime(s0) ^ s0 ^ s1 ^ s2 ^ aes_pkg::xtime(s3);
    end
  end

  // addroundkey
  assign state_out = (final_round ? shifted : mixed) ^ round_key;

endmodule

// File: aes_top.sv
`timescale 1ns/1ps
module aes_top #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  aes_block_if blk ();  // job between the three parts

  aes_axil_write #(.ADDR_W(ADDR_W)) i_axil_write (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .blk     (blk.host)
  );

  aes_core i_core (
    .clk   (clk),
    .reset (reset),
    .blk   (blk.engine)
  );

  aes_axil_read #(.ADDR_W(ADDR_W)) i_axil_read (
    .clk     (clk),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .blk     (blk.monitor)
  );

endmodule

// File: aes_vectors.txt
// one vector per line, 96 hex digits: key (digits 1-32), plaintext (33-64),
// expected ciphertext (65-96), all in fips-197 byte order
// fips-197 appendix b
2b7e151628aed2a6abf7158809cf4f3c3243f6a8885a308d313198a2e03707343925841d02dc09fbdc118597196a0b32
// fips-197 appendix c.1
000102030405060708090a0b0c0d0e0f00112233445566778899aabbccddeeff69c4e0d86a7b0430d8cdb78070b4c55a
// sp 800-38a ecb-aes128 blocks 1 to 4
2b7e151628aed2a6abf7158809cf4f3c6bc1bee22e409f96e93d7e117393172a3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3cae2d8a571e03ac9c9eb76fac45af8e51f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c30c81c46a35ce411e5fbc1191a0a52ef43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3cf69f2445df4f9b17ad2b417be66c37107b0c785e27e8ad3f8223207104725dd4

// File: project.f
aes_pkg.sv
aes_block_if.sv
aes_key_sched.sv
aes_round.sv
aes_core.sv
aes_axil_write.sv
aes_axil_read.sv
aes_top.sv
tb_aes.sv

// File: tb_aes.sv
`timescale 1ns/1ps
module tb_aes;

  localparam int          ADDR_W      = 8;
  localparam int          NUM_VEC     = 6;                    // lines in aes_vectors.txt
  localparam int          CYCLE_LIMIT = NUM_VEC * 300 + 200;  // kat loop plus directed tests
  localparam logic [31:0] SEED        = 32'h1b9b_f8f8;

  logic              clk;
  logic              reset;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [31:0]       rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  logic [383:0] vectors [0:NUM_VEC-1];  // key, plaintext, ciphertext
  int           cycles;
  int           max_stall;              // upper bound of bready/rready stall

  aes_top #(.ADDR_W(ADDR_W)) i_aes_top (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Something failed");
      $fatal(1, "timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [7:0] base, input int n);
    return ADDR_W'(base) + ADDR_W'(4 * n);
  endfunction

  // word n holds bytes 4n..4n+3 with byte 4n in bits 31:24
  function automatic logic [31:0] block_word(input logic [127:0] blk, input int n);
    return blk[127 - 32*n -: 32];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Something failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // called right after a rising edge and returns right after one
  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
    int stall;
    stall = $urandom_range(max_stall, 0);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    do
      @(posedge clk);
    while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk);
      check_value("bvalid held", 32'(bvalid), 32'h1);  // back-pressure
    end
    bready <= 1'b1;
    do
      @(posedge clk);
    while (!bvalid);
    bready <= 1'b0;
    check_value($sformatf("bresp at 0x%h", addr), 32'(bresp), 32'(exp_resp));
    @(posedge clk);
    check_value("bvalid after handshake", 32'(bvalid), 32'h0);  // exactly one response
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int stall;
    stall = $urandom_range(max_stall, 0);
    araddr  <= addr;
    arvalid <= 1'b1;
    do
      @(posedge clk);
    while (!arready);
    arvalid <= 1'b0;
    for (int i = 0; i < stall; i++)
    begin
      @(posedge clk);
      check_value("rvalid held", 32'(rvalid), 32'h1);
    end
    rready <= 1'b1;
    do
      @(posedge clk);
    while (!rvalid);
    rready <= 1'b0;
    data = rdata;
    resp = rresp;
    @(posedge clk);
    check_value("rvalid after handshake", 32'(rvalid), 32'h0);
  endtask

  task automatic expect_word(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_word(addr, data, resp);
    check_value($sformatf("%s rdata", name), data, exp_data);
    check_value($sformatf("%s rresp", name), 32'(resp), 32'(exp_resp));
  endtask

  task automatic load_block(input logic [7:0] base, input logic [127:0] blk);
    for (int n = 0; n < 4; n++)
      write_word(reg_addr(base, n), block_word(blk, n), 4'hf, aes_pkg::RESP_OKAY);
  endtask

  task automatic poll_done();
    logic [31:0] status;
    logic [1:0]  resp;
    do
    begin
      read_word(reg_addr(aes_pkg::REG_STATUS, 0), status, resp);
      check_value("status poll rresp", 32'(resp), 32'(aes_pkg::RESP_OKAY));
    end
    while (!status[1]);  // bit 1 done
  endtask

  initial
  begin
    logic [127:0] key;
    logic [127:0] pt;
    logic [127:0] ct;
    logic [127:0] new_pt;
    void'($urandom(SEED));
    $readmemh("aes_vectors.txt", vectors);
    reset   <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    max_stall = 3;
    repeat (10) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);

    // known answers back to back where each start clears the previous done
    for (int v = 0; v < NUM_VEC; v++)
    begin
      load_block(aes_pkg::REG_KEY0, vectors[v][383:256]);
      load_block(aes_pkg::REG_PT0, vectors[v][255:128]);
      write_word(reg_addr(aes_pkg::REG_CTRL, 0), 32'h1, 4'hf, aes_pkg::RESP_OKAY);
      poll_done();
      for (int n = 0; n < 4; n++)
        expect_word($sformatf("vector %0d CT%0d", v, n), reg_addr(aes_pkg::REG_CT0, n),
                    block_word(vectors[v][127:0], n), aes_pkg::RESP_OKAY);
    end

    key    = vectors[1][383:256];
    pt     = vectors[1][255:128];
    ct     = vectors[1][127:0];
    new_pt = vectors[2][255:128];
    load_block(aes_pkg::REG_KEY0, key);
    load_block(aes_pkg::REG_PT0, pt);
    max_stall = 0;  // status read, PT0 write and second start all within the 10 busy cycles
    write_word(reg_addr(aes_pkg::REG_CTRL, 0), 32'h1, 4'hf, aes_pkg::RESP_OKAY);
    expect_word("status while busy", reg_addr(aes_pkg::REG_STATUS, 0), 32'h1,
                aes_pkg::RESP_OKAY);
    write_word(reg_addr(aes_pkg::REG_PT0, 0), block_word(new_pt, 0), 4'hf,
               aes_pkg::RESP_OKAY);  // a restart would now give another block
    write_word(reg_addr(aes_pkg::REG_CTRL, 0), 32'h1, 4'hf, aes_pkg::RESP_OKAY);  // dropped
    for (int n = 1; n < 4; n++)
      write_word(reg_addr(aes_pkg::REG_PT0, n), block_word(new_pt, n), 4'hf,
                 aes_pkg::RESP_OKAY);
    max_stall = 3;
    poll_done();
    expect_word("status after done", reg_addr(aes_pkg::REG_STATUS, 0), 32'h2,
                aes_pkg::RESP_OKAY);
    for (int n = 0; n < 4; n++)
    begin
      expect_word($sformatf("busy start CT%0d", n), reg_addr(aes_pkg::REG_CT0, n),
                  block_word(ct, n), aes_pkg::RESP_OKAY);
      expect_word($sformatf("rewritten PT%0d", n), reg_addr(aes_pkg::REG_PT0, n),
                  block_word(new_pt, n), aes_pkg::RESP_OKAY);
    end

    // only lane 2 (bits 23:16) replaced
    write_word(reg_addr(aes_pkg::REG_PT0, 1), 32'h11223344, 4'hf, aes_pkg::RESP_OKAY);
    write_word(reg_addr(aes_pkg::REG_PT0, 1), 32'haabbccdd, 4'b0100, aes_pkg::RESP_OKAY);
    expect_word("strobed PT1", reg_addr(aes_pkg::REG_PT0, 1), 32'h11bb3344,
                aes_pkg::RESP_OKAY);
    for (int n = 0; n < 4; n++)
      expect_word($sformatf("KEY%0d", n), reg_addr(aes_pkg::REG_KEY0, n), 32'h0,
                  aes_pkg::RESP_OKAY);
    expect_word("CTRL", reg_addr(aes_pkg::REG_CTRL, 0), 32'h0, aes_pkg::RESP_OKAY);

    // read-only registers take the write and keep their value
    write_word(reg_addr(aes_pkg::REG_STATUS, 0), 32'h0, 4'hf, aes_pkg::RESP_OKAY);
    write_word(reg_addr(aes_pkg::REG_CT0, 0), 32'hffffffff, 4'hf, aes_pkg::RESP_OKAY);
    expect_word("status after write", reg_addr(aes_pkg::REG_STATUS, 0), 32'h2,
                aes_pkg::RESP_OKAY);
    expect_word("CT0 after write", reg_addr(aes_pkg::REG_CT0, 0), block_word(ct, 0),
                aes_pkg::RESP_OKAY);

    // outside the map
    write_word(reg_addr(8'h40, 0), 32'hdeadbeef, 4'hf, aes_pkg::RESP_SLVERR);
    expect_word("unmapped", reg_addr(8'h40, 0), 32'h0, aes_pkg::RESP_SLVERR);

    $display("Everything OK");
    $finish;
  end

endmodule
